/* excp_pkg.sv */
`default_nettype none

package excp_pkg;

    localparam int EXC_NUM   = 16;
    localparam int EXC_IDX_W = $clog2(EXC_NUM);

    typedef logic [EXC_NUM-1:0]   excp_vec_t;   // bit 0 has top priority
    typedef logic [EXC_IDX_W-1:0] excp_idx_t;
    typedef logic [5:0]           ecode_t;
    typedef logic [8:0]           esubcode_t;

    // cause positions in the vector, fetch side first then memory side
    localparam excp_idx_t EXC_INT    = 4'd0;
    localparam excp_idx_t EXC_ADEF   = 4'd1;
    localparam excp_idx_t EXC_TLBR_F = 4'd2;
    localparam excp_idx_t EXC_PIF    = 4'd3;
    localparam excp_idx_t EXC_PPI_F  = 4'd4;
    localparam excp_idx_t EXC_SYS    = 4'd5;
    localparam excp_idx_t EXC_BRK    = 4'd6;
    localparam excp_idx_t EXC_INE    = 4'd7;
    localparam excp_idx_t EXC_IPE    = 4'd8;
    localparam excp_idx_t EXC_ALE    = 4'd9;
    localparam excp_idx_t EXC_ADEM   = 4'd10;
    localparam excp_idx_t EXC_TLBR_M = 4'd11;
    localparam excp_idx_t EXC_PME    = 4'd12;
    localparam excp_idx_t EXC_PPI_M  = 4'd13;
    localparam excp_idx_t EXC_PIS    = 4'd14;
    localparam excp_idx_t EXC_PIL    = 4'd15;

    localparam ecode_t ECODE_INT  = 6'h00;
    localparam ecode_t ECODE_PIL  = 6'h01;
    localparam ecode_t ECODE_PIS  = 6'h02;
    localparam ecode_t ECODE_PIF  = 6'h03;
    localparam ecode_t ECODE_PME  = 6'h04;
    localparam ecode_t ECODE_PPI  = 6'h07;
    localparam ecode_t ECODE_ADE  = 6'h08;  // shared by fetch and memory, split by subcode
    localparam ecode_t ECODE_ALE  = 6'h09;
    localparam ecode_t ECODE_SYS  = 6'h0b;
    localparam ecode_t ECODE_BRK  = 6'h0c;
    localparam ecode_t ECODE_INE  = 6'h0d;
    localparam ecode_t ECODE_IPE  = 6'h0e;
    localparam ecode_t ECODE_TLBR = 6'h3f;

    localparam esubcode_t ESUBCODE_ADEF = 9'd0;
    localparam esubcode_t ESUBCODE_ADEM = 9'd1;

    // addresses kept at the core's 32-bit pc width
    typedef struct packed {
        logic        valid;
        ecode_t      ecode;
        esubcode_t   esubcode;
        logic        va_valid;
        logic [31:0] bad_va;
        logic [31:0] era;
    } excp_info_t;

endpackage

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int INSTR_W    = 32;
    localparam int OP_W       = 8;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 14;
    localparam int FTQ_SIZE   = 8;
    localparam int FTQ_ID_W   = $clog2(FTQ_SIZE);
    localparam int STALL_W    = 5;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [OP_W-1:0]       op_t;
    typedef logic [FTQ_ID_W-1:0]   ftq_id_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [STALL_W-1:0]    stall_t;  // {mem_wb, ex_mem, dispatch_ex, id_dispatch, -}

    localparam op_t OP_NOP     = 8'h00;
    localparam op_t OP_ALU     = 8'h01;
    localparam op_t OP_ERTN    = 8'h40;
    localparam op_t OP_SYSCALL = 8'h41;
    localparam op_t OP_BREAK   = 8'h42;
    localparam op_t OP_IDLE    = 8'h43;

    // stall patterns, bit 0 never used
    localparam stall_t STALL_NONE = 5'b00000;
    localparam stall_t STALL_FULL = 5'b11110;  // hold everything up to mem_wb
    localparam stall_t STALL_DISP = 5'b11100;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        data_t     data;
    } reg_wr_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        data_t     data;
    } csr_wr_t;

    typedef struct packed {
        logic                valid;
        op_t                 op;
        addr_t               pc;
        instr_t              instr;
        logic                excp;
        excp_pkg::excp_vec_t excp_vec;
        addr_t               mem_addr;
        logic                last_in_block;
        ftq_id_t             ftq_id;
        logic                fetch_flush;  // refetch after this instr
        reg_wr_t             reg_wr;
        csr_wr_t             csr_wr;
    } wb_lane_t;

endpackage

`default_nettype wire

/* excp_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module excp_encoder
    import core_pkg::*;
    import excp_pkg::*;
(
    input  excp_vec_t  excp_vec_i,
    input  addr_t      pc_i,
    input  addr_t      va_i,
    input  logic       is_idle_i,
    output excp_info_t info_o
);

    excp_idx_t cause;
    logic      hit;
    logic      fetch_cause;
    logic      mem_cause;

    // lowest set bit wins
    always_comb begin
        cause = '0;
        hit   = 1'b0;
        for (int i = EXC_NUM - 1; i >= 0; i--) begin
            if (excp_vec_i[i]) begin
                cause = excp_idx_t'(i);
                hit   = 1'b1;
            end
        end
    end

    assign fetch_cause = hit && (cause >= EXC_ADEF) && (cause <= EXC_PPI_F);
    assign mem_cause   = hit && (cause >= EXC_ALE);

    always_comb begin
        info_o          = '0;
        info_o.valid    = hit;
        info_o.era      = is_idle_i ? pc_i + 32'd4 : pc_i;  // resume past idle
        info_o.va_valid = fetch_cause | mem_cause;
        if (fetch_cause) begin
            info_o.bad_va = pc_i;
        end else if (mem_cause) begin
            info_o.bad_va = va_i;
        end
        case (cause)
            EXC_INT:    info_o.ecode = ECODE_INT;
            EXC_ADEF: begin
                info_o.ecode    = ECODE_ADE;
                info_o.esubcode = ESUBCODE_ADEF;
            end
            EXC_TLBR_F: info_o.ecode = ECODE_TLBR;
            EXC_PIF:    info_o.ecode = ECODE_PIF;
            EXC_PPI_F:  info_o.ecode = ECODE_PPI;
            EXC_SYS:    info_o.ecode = ECODE_SYS;
            EXC_BRK:    info_o.ecode = ECODE_BRK;
            EXC_INE:    info_o.ecode = ECODE_INE;
            EXC_IPE:    info_o.ecode = ECODE_IPE;
            EXC_ALE:    info_o.ecode = ECODE_ALE;
            EXC_ADEM: begin
                info_o.ecode    = ECODE_ADE;
                info_o.esubcode = ESUBCODE_ADEM;
            end
            EXC_TLBR_M: info_o.ecode = ECODE_TLBR;
            EXC_PME:    info_o.ecode = ECODE_PME;
            EXC_PPI_M:  info_o.ecode = ECODE_PPI;
            EXC_PIS:    info_o.ecode = ECODE_PIS;
            EXC_PIL:    info_o.ecode = ECODE_PIL;
            default:    info_o.ecode = ECODE_INT;
        endcase
    end

    // a reported cause must point at a bit that is really set
    always_comb begin
        if (info_o.valid) begin
            assert (excp_vec_i != '0 && excp_vec_i[cause])
                else $error("excp_encoder: valid info without matching cause bit");
        end
    end

endmodule

`default_nettype wire

/* stall_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module stall_ctrl
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inv_req_i,
    input  logic [1:0] mem_req_i,
    input  logic [1:0] ex_req_i,
    input  logic       dispatch_req_i,
    input  logic       is_pri_issue_i,
    input  logic       pri_commit_i,
    input  logic       excp_flush_i,
    output stall_t     stall_o,
    output logic       pri_stall_o
);

    // memory and execute requests freeze the front stages
    always_comb begin
        if (inv_req_i || (|mem_req_i) || (|ex_req_i)) begin
            stall_o = STALL_FULL;
        end else if (dispatch_req_i) begin
            stall_o = STALL_DISP;
        end else begin
            stall_o = STALL_NONE;
        end
    end

    // blocks issue until the privileged instr leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            pri_stall_o <= 1'b0;
        end else if (is_pri_issue_i) begin
            pri_stall_o <= 1'b1;  // new issue beats a clear
        end else if (pri_commit_i || excp_flush_i) begin
            pri_stall_o <= 1'b0;
        end
    end

    a_stall_bit0: assert property (@(posedge clk) disable iff (rst) !stall_o[0])
        else $error("stall_ctrl: unused stall bit set");

endmodule

`default_nettype wire

/* commit_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_ctrl
    import core_pkg::*;
    import excp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  wb_lane_t   lane0_i,
    input  wb_lane_t   lane1_i,
    input  logic       lane0_branch_i,
    output logic [1:0] block_commit_o,
    output ftq_id_t    flush_ftq_id_o,
    output reg_wr_t    reg_wr0_o,
    output reg_wr_t    reg_wr1_o,
    output csr_wr_t    csr_wr0_o,
    output csr_wr_t    csr_wr1_o,
    output logic       excp_flush_o,
    output logic       ertn_flush_o,
    output logic       idle_flush_o,
    output logic       fetch_flush_o,
    output logic       flush_o,
    output logic [1:0] pipe_flush_o,
    output logic       pri_commit_o,
    output addr_t      idle_pc_o,
    output excp_info_t excp_info_o
);

    logic      lane0_special;
    logic      lane0_ok;        // lane 0 valid and clean
    logic      commit1;
    logic      lane1_ok;
    logic      excp0;
    logic      excp1;
    logic      ertn0;
    logic      ertn1;
    logic      fetch0;
    logic      fetch1;
    logic      cause0;          // lane 0 ends the flow
    excp_vec_t sel_vec;
    addr_t     sel_pc;
    addr_t     sel_va;
    logic      sel_idle;

    assign lane0_special = lane0_i.op inside {OP_ERTN, OP_SYSCALL, OP_BREAK, OP_IDLE};

    assign excp0    = lane0_i.valid & lane0_i.excp;
    assign lane0_ok = lane0_i.valid & ~lane0_i.excp;
    // younger lane dies behind a fault or a flow-changing op
    assign commit1  = lane1_i.valid & ~(lane0_i.valid & (lane0_i.excp | lane0_special));
    assign excp1    = commit1 & lane1_i.excp;
    assign lane1_ok = commit1 & ~lane1_i.excp;

    assign ertn0  = lane0_ok & (lane0_i.op == OP_ERTN);
    assign ertn1  = lane1_ok & (lane1_i.op == OP_ERTN);
    assign fetch0 = lane0_ok & lane0_i.fetch_flush;
    assign fetch1 = lane1_ok & lane1_i.fetch_flush;

    assign reg_wr0_o = lane0_ok ? lane0_i.reg_wr : '0;
    assign reg_wr1_o = lane1_ok ? lane1_i.reg_wr : '0;
    assign csr_wr0_o = lane0_ok ? lane0_i.csr_wr : '0;
    assign csr_wr1_o = lane1_ok ? lane1_i.csr_wr : '0;

    assign excp_flush_o  = excp0 | excp1;
    assign ertn_flush_o  = ertn0 | ertn1;
    assign idle_flush_o  = lane0_ok & (lane0_i.op == OP_IDLE);
    assign fetch_flush_o = fetch0 | fetch1;
    assign flush_o       = excp_flush_o | ertn_flush_o | idle_flush_o | fetch_flush_o;

    // lane 1 later stages also go on a lane 0 branch
    assign pipe_flush_o[0] = excp_flush_o | ertn_flush_o;
    assign pipe_flush_o[1] = excp_flush_o | ertn_flush_o | lane0_branch_i;

    assign cause0 = excp0 | ertn0 | idle_flush_o | fetch0;

    assign block_commit_o[0] = lane0_i.valid & (lane0_i.last_in_block | cause0);
    assign block_commit_o[1] = commit1 & (lane1_i.last_in_block | excp1 | ertn1 | fetch1);

    always_comb begin
        if (cause0) begin
            flush_ftq_id_o = lane0_i.ftq_id;
        end else if (excp1) begin
            flush_ftq_id_o = lane1_i.ftq_id;
        end else begin
            flush_ftq_id_o = '0;
        end
    end

    // privileged instrs issue alone, so they always sit in lane 0
    assign pri_commit_o = lane0_i.valid & (lane0_special | lane0_i.csr_wr.we);
    assign idle_pc_o    = lane0_i.pc;

    // older faulting lane feeds the encoder
    always_comb begin
        sel_vec  = '0;
        sel_pc   = '0;
        sel_va   = '0;
        sel_idle = 1'b0;
        if (excp0) begin
            sel_vec  = lane0_i.excp_vec;
            sel_pc   = lane0_i.pc;
            sel_va   = lane0_i.mem_addr;
            sel_idle = lane0_i.op == OP_IDLE;
        end else if (excp1) begin
            sel_vec  = lane1_i.excp_vec;
            sel_pc   = lane1_i.pc;
            sel_va   = lane1_i.mem_addr;
            sel_idle = lane1_i.op == OP_IDLE;
        end
    end

    excp_encoder u_excp_encoder (
        .excp_vec_i (sel_vec),
        .pc_i       (sel_pc),
        .va_i       (sel_va),
        .is_idle_i  (sel_idle),
        .info_o     (excp_info_o)
    );

    a_flush_excl: assert property (@(posedge clk) disable iff (rst)
        !(excp_flush_o && ertn_flush_o))
        else $error("commit_ctrl: exception and ertn flush together");

endmodule

`default_nettype wire

/* excp_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module excp_csr
    import core_pkg::*;
    import excp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       excp_flush_i,
    input  excp_info_t info_i,
    output addr_t      era_o,
    output addr_t      badv_o,
    output ecode_t     ecode_o,
    output esubcode_t  esub_o
);

    // era and estat follow every exception commit
    always_ff @(posedge clk) begin
        if (rst) begin
            era_o   <= '0;
            ecode_o <= '0;
            esub_o  <= '0;
        end else if (excp_flush_i) begin
            era_o   <= info_i.era;
            ecode_o <= info_i.ecode;
            esub_o  <= info_i.esubcode;
        end
    end

    // badv only for address faults
    always_ff @(posedge clk) begin
        if (rst) begin
            badv_o <= '0;
        end else if (excp_flush_i && info_i.va_valid) begin
            badv_o <= info_i.bad_va;
        end
    end

endmodule

`default_nettype wire

/* commit_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_unit_top
    import core_pkg::*;
    import excp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  wb_lane_t   lane0_i,
    input  wb_lane_t   lane1_i,
    input  logic       lane0_branch_i,
    input  logic       inv_req_i,
    input  logic [1:0] mem_req_i,
    input  logic [1:0] ex_req_i,
    input  logic       dispatch_req_i,
    input  logic       is_pri_issue_i,
    output logic [1:0] block_commit_o,
    output ftq_id_t    flush_ftq_id_o,
    output reg_wr_t    reg_wr0_o,
    output reg_wr_t    reg_wr1_o,
    output csr_wr_t    csr_wr0_o,
    output csr_wr_t    csr_wr1_o,
    output logic       excp_flush_o,
    output logic       ertn_flush_o,
    output logic       idle_flush_o,
    output logic       fetch_flush_o,
    output logic       flush_o,
    output logic [1:0] pipe_flush_o,
    output addr_t      idle_pc_o,
    output stall_t     stall_o,
    output logic       pri_stall_o,
    output addr_t      era_o,
    output ecode_t     estat_ecode_o,
    output esubcode_t  estat_esub_o,
    output addr_t      badv_o
);

    logic       pri_commit;
    excp_info_t excp_info;

    commit_ctrl u_commit_ctrl (
        .clk            (clk),
        .rst            (rst),
        .lane0_i        (lane0_i),
        .lane1_i        (lane1_i),
        .lane0_branch_i (lane0_branch_i),
        .block_commit_o (block_commit_o),
        .flush_ftq_id_o (flush_ftq_id_o),
        .reg_wr0_o      (reg_wr0_o),
        .reg_wr1_o      (reg_wr1_o),
        .csr_wr0_o      (csr_wr0_o),
        .csr_wr1_o      (csr_wr1_o),
        .excp_flush_o   (excp_flush_o),
        .ertn_flush_o   (ertn_flush_o),
        .idle_flush_o   (idle_flush_o),
        .fetch_flush_o  (fetch_flush_o),
        .flush_o        (flush_o),
        .pipe_flush_o   (pipe_flush_o),
        .pri_commit_o   (pri_commit),
        .idle_pc_o      (idle_pc_o),
        .excp_info_o    (excp_info)
    );

    stall_ctrl u_stall_ctrl (
        .clk            (clk),
        .rst            (rst),
        .inv_req_i      (inv_req_i),
        .mem_req_i      (mem_req_i),
        .ex_req_i       (ex_req_i),
        .dispatch_req_i (dispatch_req_i),
        .is_pri_issue_i (is_pri_issue_i),
        .pri_commit_i   (pri_commit),
        .excp_flush_i   (excp_flush_o),
        .stall_o        (stall_o),
        .pri_stall_o    (pri_stall_o)
    );

    excp_csr u_excp_csr (
        .clk          (clk),
        .rst          (rst),
        .excp_flush_i (excp_flush_o),
        .info_i       (excp_info),
        .era_o        (era_o),
        .badv_o       (badv_o),
        .ecode_o      (estat_ecode_o),
        .esub_o       (estat_esub_o)
    );

endmodule

`default_nettype wire

/* commit_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_checker
    import core_pkg::*;
    import excp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  int          vec_id_i,
    input  wb_lane_t    lane0_i,
    input  wb_lane_t    lane1_i,
    input  logic        branch_i,
    input  logic [31:0] exp_i [16],
    input  logic [1:0]  block_commit_i,
    input  ftq_id_t     flush_ftq_id_i,
    input  reg_wr_t     reg_wr0_i,
    input  reg_wr_t     reg_wr1_i,
    input  csr_wr_t     csr_wr0_i,
    input  csr_wr_t     csr_wr1_i,
    input  logic        excp_flush_i,
    input  logic        ertn_flush_i,
    input  logic        idle_flush_i,
    input  logic        fetch_flush_i,
    input  logic        flush_i,
    input  logic [1:0]  pipe_flush_i,
    input  addr_t       idle_pc_i,
    input  stall_t      stall_i,
    input  logic        pri_stall_i,
    input  addr_t       era_i,
    input  ecode_t      ecode_i,
    input  esubcode_t   esub_i,
    input  addr_t       badv_i,
    output int          done_id_o,
    output int          pass_cnt_o,
    output int          fail_cnt_o
);

    // columns of the expected block
    localparam int X_BC    = 0;
    localparam int X_FID   = 1;
    localparam int X_K0    = 2;
    localparam int X_K1    = 3;
    localparam int X_XF    = 4;
    localparam int X_EF    = 5;
    localparam int X_IDF   = 6;
    localparam int X_FFL   = 7;
    localparam int X_FL    = 8;
    localparam int X_STALL = 9;
    localparam int X_PRI   = 10;
    localparam int X_CSR   = 11;
    localparam int X_EC    = 12;
    localparam int X_ES    = 13;
    localparam int X_ERA   = 14;
    localparam int X_BADV  = 15;

    int seen_id;
    int comb_errs;

    function automatic int diff(int id, string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %0d ns: vector %0d %s is %0h, expected %0h", $time, id, what, got, exp);
            return 1;
        end
        return 0;
    endfunction

    // combinational outputs are sampled on the edge after the inputs were driven
    always @(posedge clk) begin
        int      e;
        reg_wr_t r0;
        reg_wr_t r1;
        csr_wr_t c0;
        csr_wr_t c1;
        logic    xe;
        r0 = exp_i[X_K0][0] ? lane0_i.reg_wr : '0;
        r1 = exp_i[X_K1][0] ? lane1_i.reg_wr : '0;
        c0 = exp_i[X_K0][0] ? lane0_i.csr_wr : '0;
        c1 = exp_i[X_K1][0] ? lane1_i.csr_wr : '0;
        xe = exp_i[X_XF][0] | exp_i[X_EF][0];  // both squash the whole pipe
        e  = 0;
        if (rst) begin
            seen_id <= 0;
        end else if (vec_id_i != seen_id) begin
            e += diff(vec_id_i, "block_commit", 64'(block_commit_i), 64'(exp_i[X_BC]));
            e += diff(vec_id_i, "flush_ftq_id", 64'(flush_ftq_id_i), 64'(exp_i[X_FID]));
            e += diff(vec_id_i, "reg_wr0", 64'(reg_wr0_i), 64'(r0));
            e += diff(vec_id_i, "reg_wr1", 64'(reg_wr1_i), 64'(r1));
            e += diff(vec_id_i, "csr_wr0", 64'(csr_wr0_i), 64'(c0));
            e += diff(vec_id_i, "csr_wr1", 64'(csr_wr1_i), 64'(c1));
            e += diff(vec_id_i, "excp_flush", 64'(excp_flush_i), 64'(exp_i[X_XF][0]));
            e += diff(vec_id_i, "ertn_flush", 64'(ertn_flush_i), 64'(exp_i[X_EF][0]));
            e += diff(vec_id_i, "idle_flush", 64'(idle_flush_i), 64'(exp_i[X_IDF][0]));
            e += diff(vec_id_i, "fetch_flush", 64'(fetch_flush_i), 64'(exp_i[X_FFL][0]));
            e += diff(vec_id_i, "flush", 64'(flush_i), 64'(exp_i[X_FL][0]));
            e += diff(vec_id_i, "pipe_flush", 64'(pipe_flush_i),
                      64'({xe | branch_i, xe}));
            e += diff(vec_id_i, "stall", 64'(stall_i), 64'(exp_i[X_STALL][4:0]));
            if (exp_i[X_IDF][0]) begin
                e += diff(vec_id_i, "idle_pc", 64'(idle_pc_i), 64'(lane0_i.pc));
            end
            comb_errs <= e;
            seen_id   <= vec_id_i;
        end
    end

    // registered outputs have settled by the falling edge
    always @(negedge clk) begin
        int e;
        e = comb_errs;
        if (rst) begin
            done_id_o  <= 0;
            pass_cnt_o <= 0;
            fail_cnt_o <= 0;
        end else if (done_id_o != seen_id) begin
            e += diff(seen_id, "pri_stall", 64'(pri_stall_i), 64'(exp_i[X_PRI][0]));
            if (exp_i[X_CSR][0]) begin
                e += diff(seen_id, "era", 64'(era_i), 64'(exp_i[X_ERA]));
                e += diff(seen_id, "estat.ecode", 64'(ecode_i), 64'(exp_i[X_EC][5:0]));
                e += diff(seen_id, "estat.esubcode", 64'(esub_i), 64'(exp_i[X_ES][8:0]));
                e += diff(seen_id, "badv", 64'(badv_i), 64'(exp_i[X_BADV]));
            end
            if (e == 0) begin
                $display("ok   %0d ns: vector %0d", $time, seen_id);
                pass_cnt_o <= pass_cnt_o + 1;
            end else begin
                $display("FAIL %0d ns: vector %0d had %0d mismatches", $time, seen_id, e);
                fail_cnt_o <= fail_cnt_o + 1;
            end
            done_id_o <= seen_id;
        end
    end

endmodule

`default_nettype wire

/* tb_commit_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_commit_unit
    import core_pkg::*;
    import excp_pkg::*;
();

    localparam int N_COLS     = 44;
    localparam int WAIT_LIMIT = 20;  // clock edges per vector

    logic        clk;
    logic        rst;
    wb_lane_t    lane0;
    wb_lane_t    lane1;
    logic        lane0_branch;
    logic        inv_req;
    logic [1:0]  mem_req;
    logic [1:0]  ex_req;
    logic        dispatch_req;
    logic        is_pri_issue;
    logic [31:0] exp_vals [16];
    int          vec_id;

    logic [1:0]  block_commit;
    ftq_id_t     flush_ftq_id;
    reg_wr_t     reg_wr0;
    reg_wr_t     reg_wr1;
    csr_wr_t     csr_wr0;
    csr_wr_t     csr_wr1;
    logic        excp_flush;
    logic        ertn_flush;
    logic        idle_flush;
    logic        fetch_flush;
    logic        flush;
    logic [1:0]  pipe_flush;
    addr_t       idle_pc;
    stall_t      stall;
    logic        pri_stall;
    addr_t       era;
    ecode_t      ecode;
    esubcode_t   esub;
    addr_t       badv;
    int          done_id;
    int          pass_cnt;
    int          fail_cnt;

    logic [31:0] cols[$];

    commit_unit_top dut_i (
        .clk(clk), .rst(rst), .lane0_i(lane0), .lane1_i(lane1),
        .lane0_branch_i(lane0_branch), .inv_req_i(inv_req), .mem_req_i(mem_req),
        .ex_req_i(ex_req), .dispatch_req_i(dispatch_req), .is_pri_issue_i(is_pri_issue),
        .block_commit_o(block_commit), .flush_ftq_id_o(flush_ftq_id),
        .reg_wr0_o(reg_wr0), .reg_wr1_o(reg_wr1), .csr_wr0_o(csr_wr0), .csr_wr1_o(csr_wr1),
        .excp_flush_o(excp_flush), .ertn_flush_o(ertn_flush), .idle_flush_o(idle_flush),
        .fetch_flush_o(fetch_flush), .flush_o(flush), .pipe_flush_o(pipe_flush),
        .idle_pc_o(idle_pc), .stall_o(stall), .pri_stall_o(pri_stall), .era_o(era),
        .estat_ecode_o(ecode), .estat_esub_o(esub), .badv_o(badv)
    );

    commit_checker checker_i (
        .clk(clk), .rst(rst), .vec_id_i(vec_id), .lane0_i(lane0), .lane1_i(lane1),
        .branch_i(lane0_branch), .exp_i(exp_vals), .block_commit_i(block_commit),
        .flush_ftq_id_i(flush_ftq_id), .reg_wr0_i(reg_wr0), .reg_wr1_i(reg_wr1),
        .csr_wr0_i(csr_wr0), .csr_wr1_i(csr_wr1), .excp_flush_i(excp_flush),
        .ertn_flush_i(ertn_flush), .idle_flush_i(idle_flush), .fetch_flush_i(fetch_flush),
        .flush_i(flush), .pipe_flush_i(pipe_flush), .idle_pc_i(idle_pc), .stall_i(stall),
        .pri_stall_i(pri_stall), .era_i(era), .ecode_i(ecode), .esub_i(esub),
        .badv_i(badv), .done_id_o(done_id), .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
    );

    always #20 clk = ~clk;

    function automatic int hex_digit(byte c);
        if (c >= "0" && c <= "9") return int'(c - "0");
        if (c >= "a" && c <= "f") return int'(c - "a") + 10;
        if (c >= "A" && c <= "F") return int'(c - "A") + 10;
        return -1;
    endfunction

    // splits one line into hex tokens and stops at #
    function automatic void split_hex(string s);
        logic [31:0] acc;
        bit          in_tok;
        byte         c;
        int          d;
        cols.delete();
        acc    = '0;
        in_tok = 1'b0;
        for (int i = 0; i < s.len(); i++) begin
            c = s.getc(i);
            if (c == "#") break;
            d = hex_digit(c);
            if (d >= 0) begin
                acc    = {acc[27:0], 4'(d)};
                in_tok = 1'b1;
            end else begin
                if (in_tok) cols.push_back(acc);
                acc    = '0;
                in_tok = 1'b0;
            end
        end
        if (in_tok) cols.push_back(acc);
    endfunction

    // reg and csr payloads follow from the pc
    function automatic wb_lane_t make_lane(int b);
        wb_lane_t l;
        addr_t    pc;
        pc              = cols[b+2];
        l               = '0;
        l.valid         = cols[b][0];
        l.op            = cols[b+1][7:0];
        l.pc            = pc;
        l.excp          = cols[b+3][0];
        l.excp_vec      = cols[b+4][15:0];
        l.mem_addr      = cols[b+5];
        l.last_in_block = cols[b+6][0];
        l.ftq_id        = cols[b+7][2:0];
        l.fetch_flush   = cols[b+8][0];
        l.reg_wr.we     = cols[b+9][0];
        l.reg_wr.addr   = pc[6:2];
        l.reg_wr.data   = ~pc;
        l.csr_wr.we     = cols[b+10][0];
        l.csr_wr.addr   = pc[15:2];
        l.csr_wr.data   = pc ^ 32'h5a5a_5a5a;
        return l;
    endfunction

    task automatic apply_vector();
        lane0        = make_lane(0);
        lane1        = make_lane(11);
        lane0_branch = cols[22][0];
        inv_req      = cols[23][0];
        mem_req      = cols[24][1:0];
        ex_req       = cols[25][1:0];
        dispatch_req = cols[26][0];
        is_pri_issue = cols[27][0];
        for (int i = 0; i < 16; i++) begin
            exp_vals[i] = cols[28+i];
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    bad;
        int    cnt;
        bit    timed_out;
        string line;
        clk          = 1'b0;
        rst          = 1'b1;
        lane0        = '0;
        lane1        = '0;
        lane0_branch = 1'b0;
        inv_req      = 1'b0;
        mem_req      = '0;
        ex_req       = '0;
        dispatch_req = 1'b0;
        is_pri_issue = 1'b0;
        vec_id       = 0;
        n            = 0;
        bad          = 0;
        timed_out    = 1'b0;
        for (int i = 0; i < 16; i++) begin
            exp_vals[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("commit_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open commit_stim.txt");
            bad = 1;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                if ($fgets(line, fd) == 0) break;
                split_hex(line);
                if (cols.size() == 0) continue;
                if (cols.size() != N_COLS) begin
                    $display("stim line has %0d fields instead of %0d", cols.size(), N_COLS);
                    bad++;
                    continue;
                end
                @(negedge clk);
                apply_vector();
                n++;
                vec_id = n;
                cnt    = 0;
                while (done_id != n && cnt < WAIT_LIMIT) begin
                    @(posedge clk);
                    cnt++;
                end
                if (done_id != n) begin
                    $display("timeout: checker never finished vector %0d", n);
                    timed_out = 1'b1;
                end
            end
            $fclose(fd);
        end

        $display("vectors: %0d passed, %0d failed, %0d bad stim lines", pass_cnt, fail_cnt, bad);
        if (fail_cnt == 0 && bad == 0 && n > 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* commit_unit_top.f */
excp_pkg.sv
core_pkg.sv
excp_encoder.sv
stall_ctrl.sv
commit_ctrl.sv
excp_csr.sv
commit_unit_top.sv
commit_checker.sv
tb_commit_unit.sv

/* Makefile */
TOOL       = verilator
TOP        = tb_commit_unit
FLIST      = commit_unit_top.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "sim: PASS" || (echo "sim: FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* commit_stim.txt */
# lane (x2): valid op pc excp vec mem_addr last ftq fetch_flush reg_we csr_we
# ctrl: branch inv mem ex dispatch pri_issue | expected: bc fid keep0 keep1 xf ef idf ffl fl
#   stall pri_after csr_chk ecode esub era badv
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 00 0 1 00 0 0 0
1 01 1c000000 0 0 0 0 1 0 1 0 | 1 01 1c000004 0 0 0 1 1 0 1 0 | 0 0 0 0 0 0 | 2 0 1 1 0 0 0 0 0 00 0 0 00 0 0 0
1 01 1c000010 0 0 0 1 2 0 1 0 | 1 01 1c000014 0 0 0 1 3 0 1 0 | 0 0 0 0 0 0 | 3 0 1 1 0 0 0 0 0 00 0 0 00 0 0 0
1 01 1c000100 1 1400 00a0b0c4 0 5 0 1 0 | 1 01 1c000104 0 0 0 1 6 0 1 0 | 0 0 0 0 0 0 | 1 5 0 0 1 0 0 0 1 00 0 1 08 1 1c000100 00a0b0c4
1 01 1c000200 1 0022 0 0 2 0 1 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 | 1 2 0 0 1 0 0 0 1 00 0 1 08 0 1c000200 1c000200
1 01 1c000300 1 0080 12345678 1 7 0 1 0 | 1 01 1c000304 0 0 0 0 7 0 1 0 | 0 0 0 0 0 0 | 1 7 0 0 1 0 0 0 1 00 0 1 0d 0 1c000300 1c000200
1 01 1c000400 0 0 0 0 1 0 1 0 | 1 01 1c000404 1 8000 00c0ffee 0 2 0 1 0 | 0 0 0 0 0 0 | 2 2 1 0 1 0 0 0 1 00 0 1 01 0 1c000404 00c0ffee
1 01 1c000500 0 0 0 1 3 0 1 0 | 1 01 1c000504 1 0040 0badf00d 0 4 0 1 0 | 0 0 0 0 0 0 | 3 4 1 0 1 0 0 0 1 00 0 1 0c 0 1c000504 00c0ffee
1 41 1c000600 1 0020 0 0 1 0 0 0 | 1 01 1c000604 0 0 0 1 2 0 1 0 | 0 0 0 0 0 0 | 1 1 0 0 1 0 0 0 1 00 0 1 0b 0 1c000600 00c0ffee
1 42 1c000700 1 0040 0 0 2 0 0 0 | 1 01 1c000704 0 0 0 1 3 0 1 0 | 0 0 0 0 0 0 | 1 2 0 0 1 0 0 0 1 00 0 1 0c 0 1c000700 00c0ffee
1 40 1c000800 0 0 0 0 3 0 0 0 | 1 01 1c000804 0 0 0 1 4 0 1 0 | 0 0 0 0 0 0 | 1 3 1 0 0 1 0 0 1 00 0 1 0c 0 1c000700 00c0ffee
1 43 1c000880 0 0 0 0 4 0 0 0 | 1 01 1c000884 0 0 0 1 5 0 1 0 | 0 0 0 0 0 0 | 1 4 1 0 0 0 1 0 1 00 0 1 0c 0 1c000700 00c0ffee
1 43 1c000900 1 0001 0 0 5 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 | 1 5 0 0 1 0 0 0 1 00 0 1 00 0 1c000904 00c0ffee
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 1 0 0 0 0 | 0 0 0 0 0 0 0 0 0 1e 0 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 2 0 0 0 | 0 0 0 0 0 0 0 0 0 1e 0 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 1 0 0 | 0 0 0 0 0 0 0 0 0 1e 0 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 1 0 | 0 0 0 0 0 0 0 0 0 1c 0 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 1 0 1 0 | 0 0 0 0 0 0 0 0 0 1e 0 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 2 1 0 | 0 0 0 0 0 0 0 0 0 1e 0 0 00 0 0 0
1 01 1c000a00 0 0 0 0 6 1 1 0 | 1 01 1c000a04 0 0 0 0 6 0 1 0 | 0 0 0 0 0 0 | 1 6 1 1 0 0 0 1 1 00 0 0 00 0 0 0
1 01 1c000b00 0 0 0 1 7 0 1 0 | 1 01 1c000b04 0 0 0 1 0 0 1 0 | 1 0 0 0 0 0 | 3 0 1 1 0 0 0 0 0 00 0 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 1 | 0 0 0 0 0 0 0 0 0 00 1 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 00 1 0 00 0 0 0
1 01 1c000c00 0 0 0 1 1 0 0 1 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 | 1 0 1 0 0 0 0 0 0 00 0 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 1 | 0 0 0 0 0 0 0 0 0 00 1 0 00 0 0 0
1 01 1c000d00 1 0200 00001233 0 2 0 1 0 | 1 01 1c000d04 0 0 0 1 3 0 1 0 | 0 0 0 0 0 0 | 1 2 0 0 1 0 0 0 1 00 0 1 09 0 1c000d00 00001233
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 1 | 0 0 0 0 0 0 0 0 0 00 1 0 00 0 0 0
1 01 1c000e00 0 0 0 0 4 0 0 1 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 1 | 0 0 1 0 0 0 0 0 0 00 1 0 00 0 0 0
0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 0 0 | 0 0 0 0 0 0 | 0 0 0 0 0 0 0 0 0 00 1 1 09 0 1c000d00 00001233
